// ==== rtl/fsctl_bus_pkg.sv ====
`default_nettype none

package fsctl_bus_pkg;

	localparam int reg_data_w = 32;
	localparam int reg_addr_w = 8;

	// one motor per nibble in the shared motor registers
	localparam int mt_field_w = 4;

	// ----------------------------------------
	// register map
	// ----------------------------------------
	typedef enum logic [reg_addr_w-1:0] {
		REG_CTRL         = 8'd0,
		REG_DISP         = 8'd1,
		REG_S1_SIZE      = 8'd2,
		REG_S1_WIN_POS   = 8'd3,
		REG_S1_WIN_SIZE  = 8'd4,
		REG_S1_DST_POS   = 8'd5,
		REG_S1_DST_SIZE  = 8'd6,
		REG_S2_SIZE      = 8'd7,
		REG_S2_WIN_POS   = 8'd8,
		REG_S2_WIN_SIZE  = 8'd9,
		REG_S2_DST_POS   = 8'd10,
		REG_S2_DST_SIZE  = 8'd11,
		REG_MT_ENRST     = 8'd34,
		REG_MT_STATUS    = 8'd35,
		REG_MT_STARTSTOP = 8'd36,
		REG_MT_MS        = 8'd37,
		REG_MT_DIR       = 8'd38,
		// per-motor banks, base + motor index
		REG_MT_STROKE0   = 8'd39,
		REG_MT_STEP0     = 8'd47,
		REG_MT_SPEED0    = 8'd55,
		REG_VERSION      = 8'd255
	} reg_addr_e;

	typedef struct packed {
		logic                  en;
		logic [reg_addr_w-1:0] addr;
		logic [reg_data_w-1:0] data;
	} reg_wr_t;

endpackage

`default_nettype wire

// ==== rtl/fsctl_dev_pkg.sv ====
`default_nettype none

package fsctl_dev_pkg;

	// ----------------------------------------
	// image geometry
	// ----------------------------------------
	localparam int img_w_bits = 12;
	localparam int img_h_bits = 12;

	typedef struct packed {
		logic [img_w_bits-1:0] width;
		logic [img_h_bits-1:0] height;
		logic [img_w_bits-1:0] win_left;
		logic [img_h_bits-1:0] win_top;
		logic [img_w_bits-1:0] win_width;
		logic [img_h_bits-1:0] win_height;
		logic [img_w_bits-1:0] dst_left;
		logic [img_h_bits-1:0] dst_top;
		logic [img_w_bits-1:0] dst_width;
		logic [img_h_bits-1:0] dst_height;
	} geom_t;

	// ----------------------------------------
	// stepper motors
	// ----------------------------------------
	localparam int step_w  = 16;
	localparam int speed_w = 16;
	localparam int ms_w    = 3;

	typedef struct packed {
		logic               xen;
		logic               xrst;
		logic               start;
		logic               stop;
		logic [ms_w-1:0]    ms;
		logic               dir;
		logic [step_w-1:0]  stroke;
		logic [step_w-1:0]  step;
		logic [speed_w-1:0] speed;
	} motor_ctrl_t;

	// terminal and zero position sensors plus driver state
	typedef struct packed {
		logic zpsign;
		logic tpsign;
		logic state;
	} motor_stat_t;

endpackage

`default_nettype wire

// ==== rtl/fsctl_reg_bus.sv ====
`default_nettype none

module fsctl_reg_bus
	import fsctl_bus_pkg::*;
#(
	parameter logic [reg_data_w-1:0] CORE_VERSION = 32'h0001_0000
) (
	input  wire logic                  o_clk,
	input  wire logic                  o_resetn,

	input  wire reg_wr_t               i_wr,
	input  wire logic                  i_rd_en,
	input  wire logic [reg_addr_w-1:0] i_rd_addr,
	input  wire logic [reg_data_w-1:0] i_rd_disp,
	input  wire logic [reg_data_w-1:0] i_rd_mt,
	output      logic [reg_data_w-1:0] o_rd_data,

	output      logic                  o_soft_resetn,
	output      logic                  o_cfging
);

	logic [reg_data_w-1:0] own_word;
	logic [reg_data_w-1:0] merged_word;

	// ----------------------------------------
	// global control
	// ----------------------------------------
	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			o_soft_resetn <= 1'b0;
			o_cfging      <= 1'b0;
		end else if (i_wr.en && i_wr.addr == REG_CTRL) begin
			o_soft_resetn <= i_wr.data[0];
			o_cfging      <= i_wr.data[1];
		end
	end

	always_comb begin
		own_word = '0;
		case (i_rd_addr)
			REG_CTRL: begin
				own_word[0] = o_soft_resetn;
				own_word[1] = o_cfging;
			end
			REG_VERSION: own_word = CORE_VERSION;
			default: ;
		endcase
	end

	// ----------------------------------------
	// read merge
	// ----------------------------------------
	// blocks return zero outside their own indices
	assign merged_word = own_word | i_rd_disp | i_rd_mt;

	always_ff @(posedge o_clk) begin
		if (!o_resetn)
			o_rd_data <= '0;
		else if (i_rd_en)
			o_rd_data <= merged_word;
	end

endmodule

`default_nettype wire

// ==== rtl/fsctl_display_cfg.sv ====
`default_nettype none

module fsctl_display_cfg
	import fsctl_bus_pkg::*;
	import fsctl_dev_pkg::*;
(
	input  wire logic                  o_clk,
	input  wire logic                  o_resetn,

	input  wire reg_wr_t               i_wr,
	input  wire logic [reg_addr_w-1:0] i_rd_addr,
	output      logic [reg_data_w-1:0] o_rd_word,

	input  wire logic                  i_fsync,
	input  wire logic                  i_cfging,
	output      logic                  o_fsync,

	output      logic                  o_order_1over2,
	output      logic                  o_s0_soft_resetn,
	output      logic                  o_s1_soft_resetn,
	output      logic                  o_s2_soft_resetn,
	output      geom_t                 o_s1_geom,
	output      geom_t                 o_s2_geom
);

	// height or top sits in the upper half word
	localparam int hi_lsb = 16;

	logic       stg_order;
	logic [2:0] stg_running;
	geom_t      stg_s1;
	geom_t      stg_s2;

	logic wr_s1;
	logic wr_s2;
	logic rd_s1;
	logic rd_s2;

	logic fsync_d1;
	logic fsync_d2;
	logic fsync_pos;
	logic update;

	// offset 0..4: size, win pos, win size, dst pos, dst size
	function automatic geom_t geom_wr(input geom_t g, input logic [reg_addr_w-1:0] off,
		input logic [reg_data_w-1:0] d);
		geom_t r;
		logic [img_w_bits-1:0] lo;
		logic [img_h_bits-1:0] hi;
		r  = g;
		lo = d[img_w_bits-1:0];
		hi = d[hi_lsb +: img_h_bits];
		case (off)
			0: begin
				r.width  = lo;
				r.height = hi;
			end
			1: begin
				r.win_left = lo;
				r.win_top  = hi;
			end
			2: begin
				r.win_width  = lo;
				r.win_height = hi;
			end
			3: begin
				r.dst_left = lo;
				r.dst_top  = hi;
			end
			4: begin
				r.dst_width  = lo;
				r.dst_height = hi;
			end
			default: ;
		endcase
		return r;
	endfunction

	function automatic logic [reg_data_w-1:0] geom_rd(input geom_t g,
		input logic [reg_addr_w-1:0] off);
		logic [reg_data_w-1:0] w;
		w = '0;
		case (off)
			0: begin
				w[img_w_bits-1:0]         = g.width;
				w[hi_lsb +: img_h_bits]   = g.height;
			end
			1: begin
				w[img_w_bits-1:0]         = g.win_left;
				w[hi_lsb +: img_h_bits]   = g.win_top;
			end
			2: begin
				w[img_w_bits-1:0]         = g.win_width;
				w[hi_lsb +: img_h_bits]   = g.win_height;
			end
			3: begin
				w[img_w_bits-1:0]         = g.dst_left;
				w[hi_lsb +: img_h_bits]   = g.dst_top;
			end
			4: begin
				w[img_w_bits-1:0]         = g.dst_width;
				w[hi_lsb +: img_h_bits]   = g.dst_height;
			end
			default: ;
		endcase
		return w;
	endfunction

	// ----------------------------------------
	// staged registers
	// ----------------------------------------
	assign wr_s1 = i_wr.addr >= REG_S1_SIZE && i_wr.addr <= REG_S1_DST_SIZE;
	assign wr_s2 = i_wr.addr >= REG_S2_SIZE && i_wr.addr <= REG_S2_DST_SIZE;

	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			stg_order   <= 1'b0;
			stg_running <= 3'b001;
			stg_s1      <= '0;
			stg_s2      <= '0;
		end else if (i_wr.en) begin
			if (i_wr.addr == REG_DISP) begin
				stg_order   <= i_wr.data[0];
				stg_running <= i_wr.data[3:1];
			end
			if (wr_s1)
				stg_s1 <= geom_wr(stg_s1, i_wr.addr - REG_S1_SIZE, i_wr.data);
			if (wr_s2)
				stg_s2 <= geom_wr(stg_s2, i_wr.addr - REG_S2_SIZE, i_wr.data);
		end
	end

	assign rd_s1 = i_rd_addr >= REG_S1_SIZE && i_rd_addr <= REG_S1_DST_SIZE;
	assign rd_s2 = i_rd_addr >= REG_S2_SIZE && i_rd_addr <= REG_S2_DST_SIZE;

	always_comb begin
		o_rd_word = '0;
		if (i_rd_addr == REG_DISP) begin
			o_rd_word[0]   = stg_order;
			o_rd_word[3:1] = stg_running;
		end else if (rd_s1) begin
			o_rd_word = geom_rd(stg_s1, i_rd_addr - REG_S1_SIZE);
		end else if (rd_s2) begin
			o_rd_word = geom_rd(stg_s2, i_rd_addr - REG_S2_SIZE);
		end
	end

	// ----------------------------------------
	// frame sync and live update
	// ----------------------------------------
	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			fsync_d1 <= 1'b0;
			fsync_d2 <= 1'b0;
			o_fsync  <= 1'b0;
		end else begin
			fsync_d1 <= i_fsync;
			fsync_d2 <= fsync_d1;
			o_fsync  <= fsync_pos;
		end
	end

	assign fsync_pos = fsync_d1 && !fsync_d2;
	// live values move together with o_fsync
	assign update    = fsync_pos && !i_cfging;

	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			o_order_1over2   <= 1'b0;
			o_s0_soft_resetn <= 1'b0;
			o_s1_soft_resetn <= 1'b0;
			o_s2_soft_resetn <= 1'b0;
			o_s1_geom        <= '0;
			o_s2_geom        <= '0;
		end else if (update) begin
			o_order_1over2   <= stg_order;
			o_s0_soft_resetn <= stg_running[0];
			o_s1_soft_resetn <= stg_running[1];
			o_s2_soft_resetn <= stg_running[2];
			o_s1_geom        <= stg_s1;
			o_s2_geom        <= stg_s2;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/fsctl_motor_bank.sv ====
`default_nettype none

module fsctl_motor_bank
	import fsctl_bus_pkg::*;
	import fsctl_dev_pkg::*;
#(
	parameter int MOTOR_NBR = 2
) (
	input  wire logic                          o_clk,
	input  wire logic                          o_resetn,

	input  wire reg_wr_t                       i_wr,
	input  wire logic [reg_addr_w-1:0]         i_rd_addr,
	output      logic [reg_data_w-1:0]         o_rd_word,

	input  wire motor_stat_t [MOTOR_NBR-1:0]   i_mt_stat,
	output      motor_ctrl_t [MOTOR_NBR-1:0]   o_mt_ctrl
);

	// ----------------------------------------
	// control registers
	// ----------------------------------------
	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			o_mt_ctrl <= '0;
		end else begin
			for (int m = 0; m < MOTOR_NBR; m++) begin
				// pulses last one cycle unless rewritten
				o_mt_ctrl[m].start <= 1'b0;
				o_mt_ctrl[m].stop  <= 1'b0;
				if (i_wr.en) begin
					case (i_wr.addr)
						REG_MT_ENRST: begin
							o_mt_ctrl[m].xen  <= i_wr.data[mt_field_w*m];
							o_mt_ctrl[m].xrst <= i_wr.data[mt_field_w*m + 1];
						end
						REG_MT_STARTSTOP: begin
							o_mt_ctrl[m].start <= i_wr.data[mt_field_w*m];
							o_mt_ctrl[m].stop  <= i_wr.data[mt_field_w*m + 1];
						end
						REG_MT_MS:
							o_mt_ctrl[m].ms <= i_wr.data[mt_field_w*m +: ms_w];
						REG_MT_DIR:
							o_mt_ctrl[m].dir <= i_wr.data[mt_field_w*m];
						reg_addr_w'(REG_MT_STROKE0 + m):
							o_mt_ctrl[m].stroke <= i_wr.data[step_w-1:0];
						reg_addr_w'(REG_MT_STEP0 + m):
							o_mt_ctrl[m].step <= i_wr.data[step_w-1:0];
						reg_addr_w'(REG_MT_SPEED0 + m):
							o_mt_ctrl[m].speed <= i_wr.data[speed_w-1:0];
						default: ;
					endcase
				end
			end
		end
	end

	// ----------------------------------------
	// readback
	// ----------------------------------------
	// start and stop are write-only strobes, they read as zero
	always_comb begin
		o_rd_word = '0;
		for (int m = 0; m < MOTOR_NBR; m++) begin
			case (i_rd_addr)
				REG_MT_ENRST: begin
					o_rd_word[mt_field_w*m]     = o_mt_ctrl[m].xen;
					o_rd_word[mt_field_w*m + 1] = o_mt_ctrl[m].xrst;
				end
				REG_MT_STATUS: begin
					o_rd_word[mt_field_w*m]     = i_mt_stat[m].zpsign;
					o_rd_word[mt_field_w*m + 1] = i_mt_stat[m].tpsign;
					o_rd_word[mt_field_w*m + 2] = i_mt_stat[m].state;
				end
				REG_MT_MS:
					o_rd_word[mt_field_w*m +: ms_w] = o_mt_ctrl[m].ms;
				REG_MT_DIR:
					o_rd_word[mt_field_w*m] = o_mt_ctrl[m].dir;
				reg_addr_w'(REG_MT_STROKE0 + m):
					o_rd_word[step_w-1:0] = o_mt_ctrl[m].stroke;
				reg_addr_w'(REG_MT_STEP0 + m):
					o_rd_word[step_w-1:0] = o_mt_ctrl[m].step;
				reg_addr_w'(REG_MT_SPEED0 + m):
					o_rd_word[speed_w-1:0] = o_mt_ctrl[m].speed;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/fsctl_top.sv ====
`default_nettype none

module fsctl_top
	import fsctl_bus_pkg::*;
	import fsctl_dev_pkg::*;
#(
	parameter int                    MOTOR_NBR    = 2,
	parameter logic [reg_data_w-1:0] CORE_VERSION = 32'h0001_0000
) (
	input  wire logic                        o_clk,
	input  wire logic                        o_resetn,

	// register bus
	input  wire logic                        i_rd_en,
	input  wire logic [reg_addr_w-1:0]       i_rd_addr,
	output      logic [reg_data_w-1:0]       o_rd_data,
	input  wire logic                        i_wr_en,
	input  wire logic [reg_addr_w-1:0]       i_wr_addr,
	input  wire logic [reg_data_w-1:0]       i_wr_data,

	// display
	input  wire logic                        i_fsync,
	output      logic                        o_fsync,
	output      logic                        o_soft_resetn,
	output      logic                        o_order_1over2,
	output      logic                        o_s0_soft_resetn,
	output      logic                        o_s1_soft_resetn,
	output      logic                        o_s2_soft_resetn,
	output      geom_t                       o_s1_geom,
	output      geom_t                       o_s2_geom,

	// stepper motors
	input  wire motor_stat_t [MOTOR_NBR-1:0] i_mt_stat,
	output      motor_ctrl_t [MOTOR_NBR-1:0] o_mt_ctrl
);

	reg_wr_t               bus_wr;
	logic [reg_data_w-1:0] rd_disp;
	logic [reg_data_w-1:0] rd_mt;
	logic                  cfging;

	assign bus_wr = '{en: i_wr_en, addr: i_wr_addr, data: i_wr_data};

	// ----------------------------------------
	// register blocks
	// ----------------------------------------
	fsctl_reg_bus #(
		.CORE_VERSION (CORE_VERSION)
	) u_reg_bus (
		.o_clk         (o_clk),
		.o_resetn      (o_resetn),
		.i_wr          (bus_wr),
		.i_rd_en       (i_rd_en),
		.i_rd_addr     (i_rd_addr),
		.i_rd_disp     (rd_disp),
		.i_rd_mt       (rd_mt),
		.o_rd_data     (o_rd_data),
		.o_soft_resetn (o_soft_resetn),
		.o_cfging      (cfging)
	);

	fsctl_display_cfg u_display_cfg (
		.o_clk            (o_clk),
		.o_resetn         (o_resetn),
		.i_wr             (bus_wr),
		.i_rd_addr        (i_rd_addr),
		.o_rd_word        (rd_disp),
		.i_fsync          (i_fsync),
		.i_cfging         (cfging),
		.o_fsync          (o_fsync),
		.o_order_1over2   (o_order_1over2),
		.o_s0_soft_resetn (o_s0_soft_resetn),
		.o_s1_soft_resetn (o_s1_soft_resetn),
		.o_s2_soft_resetn (o_s2_soft_resetn),
		.o_s1_geom        (o_s1_geom),
		.o_s2_geom        (o_s2_geom)
	);

	fsctl_motor_bank #(
		.MOTOR_NBR (MOTOR_NBR)
	) u_motor_bank (
		.o_clk     (o_clk),
		.o_resetn  (o_resetn),
		.i_wr      (bus_wr),
		.i_rd_addr (i_rd_addr),
		.o_rd_word (rd_mt),
		.i_mt_stat (i_mt_stat),
		.o_mt_ctrl (o_mt_ctrl)
	);

endmodule

`default_nettype wire

// ==== bench/tb_fsctl_tasks.svh ====
`ifndef TB_FSCTL_TASKS_SVH
`define TB_FSCTL_TASKS_SVH

// ----------------------------------------
// bus access and checks
// ----------------------------------------
task automatic bus_write(input logic [reg_addr_w-1:0] addr, input logic [reg_data_w-1:0] data);
	@(negedge o_clk);
	wr_en   = 1'b1;
	wr_addr = addr;
	wr_data = data;
	@(negedge o_clk);
	wr_en = 1'b0;
endtask

// read data is registered and sampled one cycle after rd_en
task automatic bus_read(input logic [reg_addr_w-1:0] addr, output logic [reg_data_w-1:0] data);
	@(negedge o_clk);
	rd_en   = 1'b1;
	rd_addr = addr;
	@(negedge o_clk);
	rd_en = 1'b0;
	data  = rd_data;
endtask

task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
	checks++;
	assert (act === exp) else begin
		errors++;
		$display("mismatch %s: expected %h actual %h", name, exp, act);
	end
endtask

task automatic check_wide(input string name, input logic [127:0] exp, input logic [127:0] act);
	checks++;
	assert (act === exp) else begin
		errors++;
		$display("mismatch %s: expected %h actual %h", name, exp, act);
	end
endtask

task automatic read_check(input string name, input logic [reg_addr_w-1:0] addr,
	input logic [reg_data_w-1:0] exp);
	logic [reg_data_w-1:0] act;
	bus_read(addr, act);
	check_word(name, exp, act);
endtask

// xorshift32
function automatic logic [31:0] rand_word();
	logic [31:0] x;
	x = rng_state;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	rng_state = x;
	return x;
endfunction

// ----------------------------------------
// expected values
// ----------------------------------------
// width or left in 11:0, height or top in 27:16
function automatic geom_t geom_from_words(input logic [31:0] w [5]);
	geom_t g;
	g.width      = w[0][11:0];
	g.height     = w[0][27:16];
	g.win_left   = w[1][11:0];
	g.win_top    = w[1][27:16];
	g.win_width  = w[2][11:0];
	g.win_height = w[2][27:16];
	g.dst_left   = w[3][11:0];
	g.dst_top    = w[3][27:16];
	g.dst_width  = w[4][11:0];
	g.dst_height = w[4][27:16];
	return g;
endfunction

// repeat a nibble field for each existing motor
function automatic logic [31:0] motor_mask(input logic [3:0] field);
	logic [31:0] m;
	m = '0;
	for (int i = 0; i < motor_nbr; i++)
		m[4*i +: 4] = field;
	return m;
endfunction

function automatic logic [31:0] pulse_bits();
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < motor_nbr; i++) begin
		v[2*i]     = mt_ctrl[i].start;
		v[2*i + 1] = mt_ctrl[i].stop;
	end
	return v;
endfunction

// ----------------------------------------
// stimulus helpers
// ----------------------------------------
task automatic write_geometry();
	for (int i = 0; i < 5; i++) begin
		s1_words[i] = rand_word();
		bus_write(8'(REG_S1_SIZE + i), s1_words[i]);
	end
	for (int i = 0; i < 5; i++) begin
		s2_words[i] = rand_word();
		bus_write(8'(REG_S2_SIZE + i), s2_words[i]);
	end
endtask

task automatic check_staged(input string name);
	for (int i = 0; i < 5; i++) begin
		read_check($sformatf("%s s1 reg %0d", name, i), 8'(REG_S1_SIZE + i),
			s1_words[i] & 32'h0FFF_0FFF);
		read_check($sformatf("%s s2 reg %0d", name, i), 8'(REG_S2_SIZE + i),
			s2_words[i] & 32'h0FFF_0FFF);
	end
endtask

// raise fsync, wait for the pulse, check live outputs in the pulse cycle
task automatic frame_check(input string name, input geom_t exp_s1, input geom_t exp_s2,
	input logic [2:0] exp_run, input logic exp_order);
	int waited;
	bit seen;
	waited   = 0;
	seen     = 1'b0;
	fsync_in = 1'b1;
	while (!seen && waited < fsync_wait) begin
		@(negedge o_clk);
		waited++;
		seen = fsync_out;
	end
	checks++;
	assert (seen) else begin
		errors++;
		$display("%s: o_fsync did not pulse within %0d cycles", name, fsync_wait);
	end
	check_wide({name, " s1 geometry"}, 128'(exp_s1), 128'(s1_geom));
	check_wide({name, " s2 geometry"}, 128'(exp_s2), 128'(s2_geom));
	check_word({name, " stream resets"}, 32'(exp_run), 32'({s2_sr, s1_sr, s0_sr}));
	check_word({name, " half order"}, 32'(exp_order), 32'(order_1over2));
	@(negedge o_clk);
	check_word({name, " fsync pulse end"}, 0, 32'(fsync_out));
	fsync_in = 1'b0;
	repeat (3) @(negedge o_clk);
endtask

// ----------------------------------------
// directed tests
// ----------------------------------------
task automatic test_reset_state();
	read_check("reset version", REG_VERSION, core_version);
	read_check("reset disp", REG_DISP, 32'h2);
	check_word("reset soft resets", 0, 32'({soft_resetn, s2_sr, s1_sr, s0_sr}));
	check_word("reset fsync", 0, 32'(fsync_out));
	check_wide("reset s1 geometry", 0, 128'(s1_geom));
	check_wide("reset s2 geometry", 0, 128'(s2_geom));
endtask

task automatic test_staged_geometry();
	write_geometry();
	disp_word = rand_word();
	bus_write(REG_DISP, disp_word);
	check_staged("staged");
	read_check("staged disp", REG_DISP, disp_word & 32'hF);
	check_wide("staged s1 live", 0, 128'(s1_geom));
	check_wide("staged s2 live", 0, 128'(s2_geom));
	frame_check("staged frame", geom_from_words(s1_words), geom_from_words(s2_words),
		disp_word[3:1], disp_word[0]);
endtask

task automatic test_cfg_gate();
	geom_t old_s1;
	geom_t old_s2;
	logic [31:0] old_disp;
	old_s1   = geom_from_words(s1_words);
	old_s2   = geom_from_words(s2_words);
	old_disp = disp_word;
	bus_write(REG_CTRL, 32'h2);
	write_geometry();
	// every display flag flips, so a leak shows
	disp_word = old_disp ^ 32'hF;
	bus_write(REG_DISP, disp_word);
	check_staged("configuring");
	frame_check("configuring frame", old_s1, old_s2, old_disp[3:1], old_disp[0]);
	bus_write(REG_CTRL, 32'h0);
	frame_check("configuring cleared frame", geom_from_words(s1_words),
		geom_from_words(s2_words), disp_word[3:1], disp_word[0]);
endtask

task automatic test_motor_levels();
	logic [31:0] enrst;
	logic [31:0] ms_word;
	logic [31:0] dir_word;
	motor_ctrl_t exp;
	enrst    = rand_word();
	ms_word  = rand_word();
	dir_word = rand_word();
	bus_write(REG_MT_ENRST, enrst);
	bus_write(REG_MT_MS, ms_word);
	bus_write(REG_MT_DIR, dir_word);
	for (int m = 0; m < motor_nbr; m++) begin
		stroke_w[m] = rand_word();
		step_w_v[m] = rand_word();
		speed_w_v[m] = rand_word();
		bus_write(8'(REG_MT_STROKE0 + m), stroke_w[m]);
		bus_write(8'(REG_MT_STEP0 + m), step_w_v[m]);
		bus_write(8'(REG_MT_SPEED0 + m), speed_w_v[m]);
	end
	for (int m = 0; m < motor_nbr; m++) begin
		exp        = '0;
		exp.xen    = enrst[4*m];
		exp.xrst   = enrst[4*m + 1];
		exp.ms     = ms_word[4*m +: 3];
		exp.dir    = dir_word[4*m];
		exp.stroke = stroke_w[m][15:0];
		exp.step   = step_w_v[m][15:0];
		exp.speed  = speed_w_v[m][15:0];
		check_wide($sformatf("motor %0d ctrl", m), 128'(exp), 128'(mt_ctrl[m]));
		read_check($sformatf("motor %0d stroke", m), 8'(REG_MT_STROKE0 + m),
			stroke_w[m] & 32'hFFFF);
		read_check($sformatf("motor %0d step", m), 8'(REG_MT_STEP0 + m),
			step_w_v[m] & 32'hFFFF);
		read_check($sformatf("motor %0d speed", m), 8'(REG_MT_SPEED0 + m),
			speed_w_v[m] & 32'hFFFF);
	end
	// fields above the last motor read as zero
	read_check("motor enrst", REG_MT_ENRST, enrst & motor_mask(4'b0011));
	read_check("motor ms", REG_MT_MS, ms_word & motor_mask(4'b0111));
	read_check("motor dir", REG_MT_DIR, dir_word & motor_mask(4'b0001));
	bus_write(8'(REG_MT_STROKE0 + motor_nbr), rand_word());
	read_check("missing motor stroke", 8'(REG_MT_STROKE0 + motor_nbr), 0);
endtask

task automatic test_start_stop();
	logic [31:0] exp;
	check_word("pulses idle", 0, pulse_bits());
	bus_write(REG_MT_STARTSTOP, 32'h10);
	check_word("motor 1 start pulse", 32'h4, pulse_bits());
	@(negedge o_clk);
	check_word("motor 1 start end", 0, pulse_bits());
	bus_write(REG_MT_STARTSTOP, 32'h2);
	check_word("motor 0 stop pulse", 32'h2, pulse_bits());
	@(negedge o_clk);
	check_word("motor 0 stop end", 0, pulse_bits());
	read_check("startstop readback", REG_MT_STARTSTOP, 0);
	for (int n = 0; n < 4; n++) begin
		exp = '0;
		for (int m = 0; m < motor_nbr; m++) begin
			mt_stat[m]     = 3'(rand_word());
			exp[4*m]       = mt_stat[m].zpsign;
			exp[4*m + 1]   = mt_stat[m].tpsign;
			exp[4*m + 2]   = mt_stat[m].state;
		end
		read_check($sformatf("motor status %0d", n), REG_MT_STATUS, exp);
	end
endtask

task automatic test_soft_reset();
	bus_write(REG_CTRL, 32'h1);
	check_word("soft reset set", 32'h1, 32'(soft_resetn));
	read_check("ctrl readback", REG_CTRL, 32'h1);
	bus_write(REG_CTRL, 32'h0);
	check_word("soft reset cleared", 0, 32'(soft_resetn));
endtask

`endif

// ==== bench/tb_fsctl.sv ====
`default_nettype none

module tb_fsctl
	import fsctl_bus_pkg::*;
	import fsctl_dev_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int                    motor_nbr    = 2;
	localparam logic [reg_data_w-1:0] core_version = 32'hA5C3_0102;
	localparam int                    fsync_wait   = 8;
	// the whole sequence runs a few hundred cycles
	localparam int                    timeout_cycles = 4000;

	logic                  o_clk;
	logic                  o_resetn;

	logic                  rd_en;
	logic [reg_addr_w-1:0] rd_addr;
	logic [reg_data_w-1:0] rd_data;
	logic                  wr_en;
	logic [reg_addr_w-1:0] wr_addr;
	logic [reg_data_w-1:0] wr_data;

	logic                  fsync_in;
	logic                  fsync_out;
	logic                  soft_resetn;
	logic                  order_1over2;
	logic                  s0_sr;
	logic                  s1_sr;
	logic                  s2_sr;
	geom_t                 s1_geom;
	geom_t                 s2_geom;

	motor_stat_t [motor_nbr-1:0] mt_stat;
	motor_ctrl_t [motor_nbr-1:0] mt_ctrl;

	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	logic [31:0] rng_state = 32'd9;

	// last values written, used to build expectations
	logic [31:0] s1_words [5];
	logic [31:0] s2_words [5];
	logic [31:0] disp_word;
	logic [31:0] stroke_w [motor_nbr];
	logic [31:0] step_w_v [motor_nbr];
	logic [31:0] speed_w_v [motor_nbr];

	fsctl_top #(
		.MOTOR_NBR    (motor_nbr),
		.CORE_VERSION (core_version)
	) u_dut (
		.o_clk            (o_clk),
		.o_resetn         (o_resetn),
		.i_rd_en          (rd_en),
		.i_rd_addr        (rd_addr),
		.o_rd_data        (rd_data),
		.i_wr_en          (wr_en),
		.i_wr_addr        (wr_addr),
		.i_wr_data        (wr_data),
		.i_fsync          (fsync_in),
		.o_fsync          (fsync_out),
		.o_soft_resetn    (soft_resetn),
		.o_order_1over2   (order_1over2),
		.o_s0_soft_resetn (s0_sr),
		.o_s1_soft_resetn (s1_sr),
		.o_s2_soft_resetn (s2_sr),
		.o_s1_geom        (s1_geom),
		.o_s2_geom        (s2_geom),
		.i_mt_stat        (mt_stat),
		.o_mt_ctrl        (mt_ctrl)
	);

	`include "tb_fsctl_tasks.svh"

	initial begin
		o_clk = 1'b0;
		forever #2 o_clk = ~o_clk;
	end

	// ----------------------------------------
	// timeout
	// ----------------------------------------
	always @(posedge o_clk) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("timeout: sequence did not finish within %0d cycles", timeout_cycles);
			$display("checks %0d, errors %0d, run timed out", checks, errors);
			$display("Result: FAILED");
			$finish;
		end
	end

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial begin
		o_resetn = 1'b0;
		rd_en    = 1'b0;
		rd_addr  = '0;
		wr_en    = 1'b0;
		wr_addr  = '0;
		wr_data  = '0;
		fsync_in = 1'b0;
		mt_stat  = '0;
		repeat (16) @(posedge o_clk);
		@(negedge o_clk);
		o_resetn = 1'b1;

		test_reset_state();
		test_staged_geometry();
		test_cfg_gate();
		test_motor_levels();
		test_start_stop();
		test_soft_reset();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+bench
rtl/fsctl_bus_pkg.sv
rtl/fsctl_dev_pkg.sv
rtl/fsctl_reg_bus.sv
rtl/fsctl_display_cfg.sv
rtl/fsctl_motor_bank.sv
rtl/fsctl_top.sv
bench/tb_fsctl.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fsctl
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert
PASS_MSG  ?= Result: PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
